/* common/i2c_init_pkg.sv */
package i2c_init_pkg;

    //////////////////////////////
    // Timing
    //////////////////////////////

    // System clock and target SCL rate
    localparam logic [31:0] CLK_FREQ_HZ = 32'd100_000_000;
    localparam logic [31:0] SCL_FREQ_HZ = 32'd100_000;

    // Each SCL period is split into four quarters, 250 cycles each at 100 MHz
    localparam logic [15:0] QUARTER_CYCLES = 16'(CLK_FREQ_HZ / (32'd4 * SCL_FREQ_HZ));

    // Number of equal synchronised samples before a line filter accepts a new level
    localparam logic [3:0] FILTER_CYCLES = 4'd3;

    // Tries per transaction before the sequencer gives up
    localparam logic [1:0] MAX_ATTEMPTS = 2'd3;

    // Number of entries in the initialisation table
    localparam logic [2:0] SEQ_LEN = 3'd5;

    //////////////////////////////
    // Bit level commands
    //////////////////////////////

    typedef enum logic [2:0] {
        BIT_START    = 3'd0,
        BIT_RSTART   = 3'd1,
        BIT_STOP     = 3'd2,
        BIT_WRITE    = 3'd3,
        BIT_ACK_READ = 3'd4
    } bit_op_t;

    // Data only matters for BIT_WRITE
    typedef struct packed {
        bit_op_t op;
        logic    data;
    } bit_cmd_t;

    //////////////////////////////
    // Init sequence table
    //////////////////////////////

    // First marks the address byte of a transaction, last marks its final byte
    typedef struct packed {
        logic       first;
        logic       last;
        logic [7:0] data;
    } seq_entry_t;

    // Switch to channel 7, then LED4 on in the CPLD control register
    localparam seq_entry_t INIT_TABLE [SEQ_LEN] = '{
        '{first: 1'b1, last: 1'b0, data: 8'hE2},
        '{first: 1'b0, last: 1'b1, data: 8'h80},
        '{first: 1'b1, last: 1'b0, data: 8'h7C},
        '{first: 1'b0, last: 1'b0, data: 8'h02},
        '{first: 1'b0, last: 1'b1, data: 8'h01}
    };

endpackage

/* hw/line_filter.sv */
`timescale 1ns/10ps

module line_filter import i2c_init_pkg::*; (
    input  logic CLK,
    input  logic reset,
    input  logic line_i,
    output logic line_o
);

    // Two flop synchroniser stages
    logic       sync1_q;
    logic       sync2_q;
    // Counts consecutive samples that differ from the current output
    logic [3:0] stable_cnt_q;

    always_ff @(posedge CLK or posedge reset) begin
        if (reset) begin
            // An open-drain bus idles high, so the filter starts there
            sync1_q      <= 1'b1;
            sync2_q      <= 1'b1;
            line_o       <= 1'b1;
            stable_cnt_q <= '0;
        end else begin
            sync1_q <= line_i;
            sync2_q <= sync1_q;
            if (sync2_q == line_o) begin
                // Any bounce back to the old level restarts the count
                stable_cnt_q <= '0;
            end else if (stable_cnt_q == FILTER_CYCLES - 4'd1) begin
                line_o       <= sync2_q;
                stable_cnt_q <= '0;
            end else begin
                stable_cnt_q <= stable_cnt_q + 4'd1;
            end
        end
    end

endmodule

/* i2c_phy/i2c_bit_ctrl.sv */
`timescale 1ns/10ps

module i2c_bit_ctrl import i2c_init_pkg::*; (
    input  logic     CLK,
    input  logic     reset,
    input  logic     bit_req_i,
    input  bit_cmd_t bit_cmd_i,
    input  logic     scl_i,
    input  logic     sda_i,
    output logic     bit_done_o,
    output logic     rx_bit_o,
    output logic     scl_oe_o,
    output logic     sda_oe_o
);

    // Every command is four quarters long
    // SCL is low in quarters 0 and 1 and released in quarters 2 and 3
    // SDA is only changed while SCL is low, or at the 2 to 3 boundary for start and stop
    logic        busy_q;
    logic [1:0]  phase_q;
    logic [15:0] qcnt_q;
    bit_cmd_t    cmd_q;

    // SDA enable applied when entering quarter 1 and quarter 3
    logic        sda_low_phase;
    logic        sda_high_phase;
    logic        quarter_end;

    always_comb begin
        case (cmd_q.op)
            BIT_WRITE: sda_low_phase = ~cmd_q.data;
            // Pull SDA low early so it can rise with SCL high
            BIT_STOP:  sda_low_phase = 1'b1;
            // Start, repeated start and ack read all release SDA here
            default:   sda_low_phase = 1'b0;
        endcase

        case (cmd_q.op)
            // SDA falls while SCL is high, which is the start condition
            BIT_START,
            BIT_RSTART: sda_high_phase = 1'b1;
            // SDA rises while SCL is high, which is the stop condition
            BIT_STOP:   sda_high_phase = 1'b0;
            default:    sda_high_phase = sda_oe_o;
        endcase
    end

    assign quarter_end = (qcnt_q == QUARTER_CYCLES - 16'd1);

    // The command is captured on acceptance and held for the whole bit
    always_ff @(posedge CLK) begin
        if (!busy_q && bit_req_i) begin
            cmd_q <= bit_cmd_i;
        end
    end

    always_ff @(posedge CLK or posedge reset) begin
        if (reset) begin
            busy_q     <= 1'b0;
            phase_q    <= '0;
            qcnt_q     <= '0;
            bit_done_o <= 1'b0;
            rx_bit_o   <= 1'b0;
            scl_oe_o   <= 1'b0;
            sda_oe_o   <= 1'b0;
        end else begin
            bit_done_o <= 1'b0;
            if (!busy_q) begin
                if (bit_req_i) begin
                    busy_q  <= 1'b1;
                    phase_q <= 2'd0;
                    qcnt_q  <= '0;
                    // A plain start begins on an idle bus and leaves SCL released
                    scl_oe_o <= (bit_cmd_i.op != BIT_START);
                end
            end else if (phase_q == 2'd2 && !scl_i) begin
                // Quarter 2 waits for SCL to read high, so a stretching slave slows us down
                qcnt_q <= '0;
            end else if (quarter_end) begin
                qcnt_q  <= '0;
                phase_q <= phase_q + 2'd1;
                case (phase_q)
                    2'd0: sda_oe_o <= sda_low_phase;
                    2'd1: scl_oe_o <= 1'b0;
                    2'd2: begin
                        // End of quarter 2 is the middle of the SCL high time
                        sda_oe_o <= sda_high_phase;
                        if (cmd_q.op == BIT_ACK_READ) begin
                            rx_bit_o <= sda_i;
                        end
                    end
                    default: begin
                        busy_q     <= 1'b0;
                        bit_done_o <= 1'b1;
                    end
                endcase
            end else begin
                qcnt_q <= qcnt_q + 16'd1;
            end
        end
    end

endmodule

/* i2c_phy/i2c_byte_shifter.sv */
`timescale 1ns/10ps

module i2c_byte_shifter import i2c_init_pkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       byte_req_i,
    input  logic [7:0] byte_data_i,
    input  logic       frame_req_i,
    input  bit_op_t    frame_op_i,
    input  logic       bit_done_i,
    input  logic       rx_bit_i,
    output logic       bit_req_o,
    output bit_cmd_t   bit_cmd_o,
    output logic       op_done_o,
    output logic       nack_o
);

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_DATA,
        SH_ACK,
        SH_FRAME
    } sh_state_t;

    sh_state_t  state_q;
    // Data bits still to send after the one in flight
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;

    // Control path
    always_ff @(posedge CLK or posedge reset) begin
        if (reset) begin
            state_q   <= SH_IDLE;
            bit_cnt_q <= '0;
            bit_req_o <= 1'b0;
            op_done_o <= 1'b0;
            nack_o    <= 1'b0;
        end else begin
            bit_req_o <= 1'b0;
            op_done_o <= 1'b0;
            case (state_q)
                SH_IDLE: begin
                    if (byte_req_i) begin
                        bit_req_o <= 1'b1;
                        bit_cnt_q <= 3'd7;
                        state_q   <= SH_DATA;
                    end else if (frame_req_i) begin
                        bit_req_o <= 1'b1;
                        state_q   <= SH_FRAME;
                    end
                end
                SH_DATA: begin
                    if (bit_done_i) begin
                        // After the eighth bit the slave gets its ack slot
                        bit_req_o <= 1'b1;
                        if (bit_cnt_q == 3'd0) begin
                            state_q <= SH_ACK;
                        end else begin
                            bit_cnt_q <= bit_cnt_q - 3'd1;
                        end
                    end
                end
                SH_ACK: begin
                    if (bit_done_i) begin
                        // SDA left high by the slave means NACK
                        nack_o    <= rx_bit_i;
                        op_done_o <= 1'b1;
                        state_q   <= SH_IDLE;
                    end
                end
                default: begin
                    if (bit_done_i) begin
                        op_done_o <= 1'b1;
                        state_q   <= SH_IDLE;
                    end
                end
            endcase
        end
    end

    // Byte and command payload, MSB goes out first
    always_ff @(posedge CLK) begin
        if (state_q == SH_IDLE && byte_req_i) begin
            shift_q   <= {byte_data_i[6:0], 1'b0};
            bit_cmd_o <= '{op: BIT_WRITE, data: byte_data_i[7]};
        end else if (state_q == SH_IDLE && frame_req_i) begin
            bit_cmd_o <= '{op: frame_op_i, data: 1'b0};
        end else if (state_q == SH_DATA && bit_done_i) begin
            if (bit_cnt_q == 3'd0) begin
                bit_cmd_o <= '{op: BIT_ACK_READ, data: 1'b0};
            end else begin
                bit_cmd_o <= '{op: BIT_WRITE, data: shift_q[7]};
                shift_q   <= {shift_q[6:0], 1'b0};
            end
        end
    end

endmodule

/* init_seq/init_seq_table.sv */
`timescale 1ns/10ps

module init_seq_table import i2c_init_pkg::*; (
    input  logic [2:0] index_i,
    output seq_entry_t entry_o
);

    // Configuration block read by the sequencer
    // Each entry carries one byte and its framing flags
    // Transaction 0 selects channel 7 of the bus switch
    // Transaction 1 writes register 0x02 of the CPLD to light LED4

    always_comb begin
        if (index_i < SEQ_LEN) begin
            entry_o = INIT_TABLE[index_i];
        end else begin
            // Past the end there is nothing to send
            entry_o = '0;
        end
    end

endmodule

/* init_seq/init_sequencer.sv */
`timescale 1ns/10ps

module init_sequencer import i2c_init_pkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       scl_idle_i,
    input  seq_entry_t entry_i,
    input  logic       op_done_i,
    input  logic       nack_i,
    output logic [2:0] index_o,
    output logic       byte_req_o,
    output logic [7:0] byte_data_o,
    output logic       frame_req_o,
    output bit_op_t    frame_op_o,
    output logic       done_o,
    output logic       error_o
);

    typedef enum logic [1:0] {
        SQ_WAIT_BUS,
        SQ_ISSUE,
        SQ_WAIT_OP,
        SQ_DONE
    } sq_state_t;

    sq_state_t  state_q;
    // Index of the address byte of the transaction in progress
    logic [2:0] first_idx_q;
    // Failed attempts of the current transaction
    logic [1:0] attempts_q;
    // Start already sent for the current transaction
    logic       open_q;
    // Next start must be a repeated start
    logic       retry_q;
    // The operation in flight is a byte rather than a framing command
    logic       byte_q;

    always_ff @(posedge CLK or posedge reset) begin
        if (reset) begin
            state_q     <= SQ_WAIT_BUS;
            index_o     <= '0;
            first_idx_q <= '0;
            attempts_q  <= '0;
            open_q      <= 1'b0;
            retry_q     <= 1'b0;
            byte_q      <= 1'b0;
            byte_req_o  <= 1'b0;
            byte_data_o <= '0;
            frame_req_o <= 1'b0;
            frame_op_o  <= BIT_STOP;
            done_o      <= 1'b0;
            error_o     <= 1'b0;
        end else begin
            byte_req_o  <= 1'b0;
            frame_req_o <= 1'b0;
            case (state_q)
                SQ_WAIT_BUS: begin
                    // Nothing is driven until both lines have come up
                    if (scl_idle_i) begin
                        state_q <= SQ_ISSUE;
                    end
                end

                //////////////////////////////
                // Issue the next command
                //////////////////////////////
                SQ_ISSUE: begin
                    state_q <= SQ_WAIT_OP;
                    if (entry_i.first && !open_q) begin
                        frame_req_o <= 1'b1;
                        frame_op_o  <= retry_q ? BIT_RSTART : BIT_START;
                        first_idx_q <= index_o;
                        open_q      <= 1'b1;
                        byte_q      <= 1'b0;
                    end else begin
                        byte_req_o  <= 1'b1;
                        byte_data_o <= entry_i.data;
                        byte_q      <= 1'b1;
                    end
                end

                SQ_WAIT_OP: begin
                    if (op_done_i) begin
                        if (byte_q && nack_i) begin
                            if (attempts_q == MAX_ATTEMPTS - 2'd1) begin
                                // Out of tries so release the bus and report
                                error_o     <= 1'b1;
                                frame_req_o <= 1'b1;
                                frame_op_o  <= BIT_STOP;
                                byte_q      <= 1'b0;
                            end else begin
                                // Rewind to the address byte and retry with a repeated start
                                attempts_q <= attempts_q + 2'd1;
                                index_o    <= first_idx_q;
                                open_q     <= 1'b0;
                                retry_q    <= 1'b1;
                                state_q    <= SQ_ISSUE;
                            end
                        end else if (byte_q) begin
                            index_o <= index_o + 3'd1;
                            if (entry_i.last) begin
                                // Transaction complete, close it with a stop
                                frame_req_o <= 1'b1;
                                frame_op_o  <= BIT_STOP;
                                byte_q      <= 1'b0;
                                attempts_q  <= '0;
                                open_q      <= 1'b0;
                                retry_q     <= 1'b0;
                            end else begin
                                state_q <= SQ_ISSUE;
                            end
                        end else if (frame_op_o == BIT_STOP) begin
                            // A stop ends the run on error or after the last entry
                            if (error_o || index_o == SEQ_LEN) begin
                                done_o  <= 1'b1;
                                state_q <= SQ_DONE;
                            end else begin
                                state_q <= SQ_ISSUE;
                            end
                        end else begin
                            state_q <= SQ_ISSUE;
                        end
                    end
                end

                // Bus released, done and error held until the next reset
                default: begin
                    state_q <= SQ_DONE;
                end
            endcase
        end
    end

endmodule

/* hw/fmc_init_master.sv */
`timescale 1ns/10ps

module fmc_init_master import i2c_init_pkg::*; (
    input  logic CLK,
    input  logic reset,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_oe_o,
    output logic sda_oe_o,
    output logic done_o,
    output logic error_o
);

    // Filtered copies of the sensed bus lines
    logic       scl_f;
    logic       sda_f;
    logic       scl_idle;

    // Sequencer to table
    logic [2:0] index;
    seq_entry_t entry;

    // Sequencer to byte shifter
    logic       byte_req;
    logic [7:0] byte_data;
    logic       frame_req;
    bit_op_t    frame_op;
    logic       op_done;
    logic       nack;

    // Byte shifter to bit controller
    logic       bit_req;
    bit_cmd_t   bit_cmd;
    logic       bit_done;
    logic       rx_bit;

    line_filter scl_filter_i (
        .CLK    (CLK),
        .reset  (reset),
        .line_i (scl_i),
        .line_o (scl_f)
    );

    line_filter sda_filter_i (
        .CLK    (CLK),
        .reset  (reset),
        .line_i (sda_i),
        .line_o (sda_f)
    );

    // The bus counts as free only when both lines read high
    assign scl_idle = scl_f & sda_f;

    init_seq_table init_seq_table_i (
        .index_i (index),
        .entry_o (entry)
    );

    init_sequencer init_sequencer_i (
        .CLK         (CLK),
        .reset       (reset),
        .scl_idle_i  (scl_idle),
        .entry_i     (entry),
        .op_done_i   (op_done),
        .nack_i      (nack),
        .index_o     (index),
        .byte_req_o  (byte_req),
        .byte_data_o (byte_data),
        .frame_req_o (frame_req),
        .frame_op_o  (frame_op),
        .done_o      (done_o),
        .error_o     (error_o)
    );

    i2c_byte_shifter i2c_byte_shifter_i (
        .CLK         (CLK),
        .reset       (reset),
        .byte_req_i  (byte_req),
        .byte_data_i (byte_data),
        .frame_req_i (frame_req),
        .frame_op_i  (frame_op),
        .bit_done_i  (bit_done),
        .rx_bit_i    (rx_bit),
        .bit_req_o   (bit_req),
        .bit_cmd_o   (bit_cmd),
        .op_done_o   (op_done),
        .nack_o      (nack)
    );

    i2c_bit_ctrl i2c_bit_ctrl_i (
        .CLK        (CLK),
        .reset      (reset),
        .bit_req_i  (bit_req),
        .bit_cmd_i  (bit_cmd),
        .scl_i      (scl_f),
        .sda_i      (sda_f),
        .bit_done_o (bit_done),
        .rx_bit_o   (rx_bit),
        .scl_oe_o   (scl_oe_o),
        .sda_oe_o   (sda_oe_o)
    );

endmodule

/* test/i2c_slave_model.sv */
`timescale 1ns/10ps

module i2c_slave_model (
    input  logic        CLK,
    input  logic        reset,
    input  logic        scl_i,
    input  logic        sda_i,
    input  logic [7:0]  nack_idx_i,
    input  logic [3:0]  nack_cnt_i,
    input  logic [15:0] stretch_len_i,
    output logic        scl_oe_o,
    output logic        sda_oe_o,
    output logic        ev_valid_o,
    output logic [8:0]  ev_code_o
);

    // Bus event codes, plain bytes use 0x00 to 0xFF
    localparam logic [8:0] EV_START  = 9'h100;
    localparam logic [8:0] EV_RSTART = 9'h101;
    localparam logic [8:0] EV_STOP   = 9'h102;

    // Line levels seen at the previous clock edge
    logic        scl_q;
    logic        sda_q;
    // A start was seen and no stop yet
    logic        busy_q;
    // 0 to 7 counts data bits, 8 waits for the ack slot, 9 is inside it
    logic [3:0]  bit_cnt_q;
    logic [7:0]  shift_q;
    // Bytes acked since reset, which selects the byte to refuse
    logic [7:0]  acked_q;
    logic [3:0]  nacks_left_q;
    // Remaining cycles of SCL held low by this slave
    logic [15:0] stretch_q;

    assign scl_oe_o = (stretch_q != 16'd0);

    always_ff @(posedge CLK or posedge reset) begin
        if (reset) begin
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            busy_q       <= 1'b0;
            bit_cnt_q    <= '0;
            shift_q      <= '0;
            acked_q      <= '0;
            nacks_left_q <= nack_cnt_i;
            stretch_q    <= '0;
            sda_oe_o     <= 1'b0;
            ev_valid_o   <= 1'b0;
            ev_code_o    <= '0;
        end else begin
            ev_valid_o <= 1'b0;
            scl_q      <= scl_i;
            sda_q      <= sda_i;
            if (stretch_q != 16'd0) begin
                stretch_q <= stretch_q - 16'd1;
            end

            //////////////////////////////
            // Start and stop conditions
            //////////////////////////////
            if (scl_q && scl_i && sda_q && !sda_i) begin
                // SDA falling under a high SCL, repeated if no stop came before
                ev_valid_o <= 1'b1;
                ev_code_o  <= busy_q ? EV_RSTART : EV_START;
                busy_q     <= 1'b1;
                bit_cnt_q  <= '0;
            end else if (scl_q && scl_i && !sda_q && sda_i) begin
                ev_valid_o <= 1'b1;
                ev_code_o  <= EV_STOP;
                busy_q     <= 1'b0;
                bit_cnt_q  <= '0;
            end else if (busy_q && !scl_q && scl_i) begin
                // Data is taken on the rising SCL edge, MSB first
                if (bit_cnt_q < 4'd8) begin
                    shift_q   <= {shift_q[6:0], sda_i};
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                    if (bit_cnt_q == 4'd7) begin
                        ev_valid_o <= 1'b1;
                        ev_code_o  <= {1'b0, shift_q[6:0], sda_i};
                    end
                end
            end else if (busy_q && scl_q && !scl_i) begin
                // Every falling edge may be stretched by the length offered this cycle
                if (stretch_len_i != 16'd0) begin
                    stretch_q <= stretch_len_i;
                end
                if (bit_cnt_q == 4'd8) begin
                    bit_cnt_q <= 4'd9;
                    if (acked_q == nack_idx_i && nacks_left_q != 4'd0) begin
                        // Leave SDA released so the master reads a NACK
                        nacks_left_q <= nacks_left_q - 4'd1;
                    end else begin
                        sda_oe_o <= 1'b1;
                        acked_q  <= acked_q + 8'd1;
                    end
                end else if (bit_cnt_q == 4'd9) begin
                    // Ack slot over, hand SDA back to the master
                    sda_oe_o  <= 1'b0;
                    bit_cnt_q <= '0;
                end
            end
        end
    end

endmodule

/* test/tb_fmc_init_master.sv */
`timescale 1ns/10ps

module tb_fmc_init_master;

    // Each case record in the data file is 32 words long
    localparam int REC_WORDS     = 32;
    localparam int MAX_CASES     = 8;
    localparam int MAX_EVENTS    = 26;
    localparam int START_TIMEOUT = 5000;
    localparam int DONE_TIMEOUT  = 400000;
    localparam int HOLD_CYCLES   = 20;

    logic        CLK;
    logic        reset;
    logic        scl_i = 1'b1;
    logic        sda_i = 1'b1;
    logic        dut_scl_oe;
    logic        dut_sda_oe;
    logic        done;
    logic        error;

    // Slave side of the bus and its per case settings
    logic        slv_scl_oe;
    logic        slv_sda_oe;
    logic [7:0]  nack_idx;
    logic [3:0]  nack_cnt;
    logic [15:0] stretch_len;
    logic [15:0] max_stretch;
    logic        ev_valid;
    logic [8:0]  ev_code;

    // Wired pull-ups where either side pulling makes the line low
    wire         scl_bus = ~(dut_scl_oe | slv_scl_oe);
    wire         sda_bus = ~(dut_sda_oe | slv_sda_oe);

    logic [15:0] case_mem [MAX_CASES * REC_WORDS];
    logic [8:0]  got_mem [MAX_EVENTS];
    int          got_cnt;
    int          case_count;
    int          fail_count;
    int          rec;
    logic [31:0] seed_word;

    fmc_init_master fmc_init_master_i (
        .CLK      (CLK),
        .reset    (reset),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .scl_oe_o (dut_scl_oe),
        .sda_oe_o (dut_sda_oe),
        .done_o   (done),
        .error_o  (error)
    );

    i2c_slave_model i2c_slave_model_i (
        .CLK           (CLK),
        .reset         (reset),
        .scl_i         (scl_bus),
        .sda_i         (sda_bus),
        .nack_idx_i    (nack_idx),
        .nack_cnt_i    (nack_cnt),
        .stretch_len_i (stretch_len),
        .scl_oe_o      (slv_scl_oe),
        .sda_oe_o      (slv_sda_oe),
        .ev_valid_o    (ev_valid),
        .ev_code_o     (ev_code)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // The DUT sees the bus through a register updated on the rising edge
    always @(posedge CLK) begin
        scl_i <= scl_bus;
        sda_i <= sda_bus;
    end

    // Record every start, stop and byte the slave decodes
    always @(posedge CLK or posedge reset) begin
        if (reset) begin
            got_cnt <= 0;
        end else if (ev_valid) begin
            if (got_cnt < MAX_EVENTS) begin
                got_mem[got_cnt] <= ev_code;
            end
            got_cnt <= got_cnt + 1;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Advances one clock and offers the slave a fresh stretch length at the edge
    task automatic step_cycle();
        logic [31:0] draw;
        @(posedge CLK);
        if (max_stretch != 16'd0) begin
            draw = $urandom % (max_stretch + 32'd1);
            stretch_len <= draw[15:0];
        end
        @(negedge CLK);
    endtask

    task automatic run_case(input int base);
        int          errs;
        int          cycles;
        int          exp_len;
        int          i;
        logic [15:0] case_id;
        logic [15:0] exp_err;
        errs    = 0;
        case_id = case_mem[base];
        exp_err = case_mem[base + 4];
        exp_len = case_mem[base + 5];
        max_stretch = case_mem[base + 3];

        @(posedge CLK);
        reset       <= 1'b1;
        nack_idx    <= case_mem[base + 1][7:0];
        nack_cnt    <= case_mem[base + 2][3:0];
        stretch_len <= '0;
        repeat (3) @(posedge CLK);
        reset <= 1'b0;
        @(negedge CLK);

        // Nothing may be driven and no flag raised before the first start
        cycles = 0;
        while (dut_sda_oe !== 1'b1 && errs == 0 && cycles < START_TIMEOUT) begin
            if (dut_scl_oe !== 1'b0) begin
                $display("Mismatch at %0t: scl_oe_o got %b expected 0", $time, dut_scl_oe);
                errs++;
            end
            if (done !== 1'b0) begin
                $display("Mismatch at %0t: done_o got %b expected 0", $time, done);
                errs++;
            end
            if (error !== 1'b0) begin
                $display("Mismatch at %0t: error_o got %b expected 0", $time, error);
                errs++;
            end
            step_cycle();
            cycles++;
        end
        if (cycles >= START_TIMEOUT) begin
            $display("Case %0d: the master never started a transfer after reset", case_id);
            errs++;
        end

        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Case %0d: done_o did not rise within %0d cycles", case_id, DONE_TIMEOUT);
            errs++;
        end else begin
            // Done and error are levels, so they must still be there a little later
            repeat (HOLD_CYCLES) step_cycle();
            if (done !== 1'b1) begin
                $display("Mismatch at %0t: done_o got %b expected 1", $time, done);
                errs++;
            end
            if (error !== exp_err[0]) begin
                $display("Mismatch at %0t: error_o got %b expected %b", $time, error,
                         exp_err[0]);
                errs++;
            end
            // The bus must be released once the run is over
            if (dut_scl_oe !== 1'b0) begin
                $display("Mismatch at %0t: scl_oe_o got %b expected 0", $time, dut_scl_oe);
                errs++;
            end
            if (dut_sda_oe !== 1'b0) begin
                $display("Mismatch at %0t: sda_oe_o got %b expected 0", $time, dut_sda_oe);
                errs++;
            end
            if (got_cnt != exp_len) begin
                $display("Mismatch at %0t: event count got %0d expected %0d", $time,
                         got_cnt, exp_len);
                errs++;
            end
            for (i = 0; i < exp_len && i < got_cnt && i < MAX_EVENTS; i++) begin
                if ({7'd0, got_mem[i]} !== case_mem[base + 6 + i]) begin
                    $display("Mismatch at %0t: event[%0d] got %h expected %h", $time, i,
                             got_mem[i], case_mem[base + 6 + i]);
                    errs++;
                end
            end
        end

        case_count++;
        if (errs == 0) begin
            $display("Case %0d: ok", case_id);
        end else begin
            fail_count++;
            $display("Case %0d: %0d error(s)", case_id, errs);
        end
    endtask

    //////////////////////////////
    // Case loop
    //////////////////////////////

    initial begin
        seed_word   = $urandom(42);
        reset       = 1'b1;
        nack_idx    = '0;
        nack_cnt    = '0;
        stretch_len = '0;
        max_stretch = '0;
        case_count  = 0;
        fail_count  = 0;
        // Unused record slots keep an all ones case id that ends the loop
        for (rec = 0; rec < MAX_CASES * REC_WORDS; rec++) begin
            case_mem[rec] = 16'hFFFF;
        end
        $readmemh("test/init_cases.txt", case_mem);

        rec = 0;
        while (rec < MAX_CASES && case_mem[rec * REC_WORDS] !== 16'hFFFF) begin
            run_case(rec * REC_WORDS);
            rec++;
        end

        $display("Summary: %0d cases run, %0d passed, %0d failed", case_count,
                 case_count - fail_count, fail_count);
        if (case_count > 0 && fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/init_cases.txt */
// Record address, case id, acked byte index to nack, nack count, max stretch cycles,
// expected error, event count, then events (bytes, 100 start, 101 repeated start, 102 stop)

// Slave acks every byte
@000 1 0 0 0   0 9 100 E2 80 102 100 7C 02 01 102
// Register byte 02 refused once, transaction 1 is resent after a repeated start
@020 2 3 1 0   0 C 100 E2 80 102 100 7C 02 101 7C 02 01 102
// Address byte E2 always refused, the master gives up after three attempts
@040 3 0 F 0   1 7 100 E2 101 E2 101 E2 102
// Random clock stretching up to 1500 cycles
@060 4 0 0 5DC 0 9 100 E2 80 102 100 7C 02 01 102
// Data byte 80 refused once, transaction 0 is resent
@080 5 1 1 0   0 C 100 E2 80 101 E2 80 102 100 7C 02 01 102

/* sources.f */
common/i2c_init_pkg.sv
hw/line_filter.sv
i2c_phy/i2c_bit_ctrl.sv
i2c_phy/i2c_byte_shifter.sv
init_seq/init_seq_table.sv
init_seq/init_sequencer.sv
hw/fmc_init_master.sv
test/i2c_slave_model.sv
test/tb_fmc_init_master.sv
